//--- cordic_coprocessor.f
common/cordic_pkg.sv
cordic_core/cordic_sequencer.sv
cordic_core/cordic_var_bank.sv
cordic_core/cordic_step_operands.sv
verilog/cordic_result_stage.sv
verilog/cordic_coprocessor.sv
verification/tb_clock_gen.sv
verification/tb_fp_adder_model.sv
verification/tb_cordic_checker.sv
verification/tb_cordic_top.sv

//--- verification/tb_cordic_top.sv
`timescale 1ns/1ps

module tb_cordic_top
	import cordic_pkg::*;
;

	localparam integer SEED     = 32'h2f58_1260;
	localparam int     OP_TOTAL = 48; // 6 + 8 + 4 + 30 computations.
	// Up to 7 cycles per transaction, two per iteration for latch and advance,
	// plus start overhead and the longest ack delay.
	localparam int CYCLES_PER_OP  = 3 * ITER_COUNT * 7 + 2 * ITER_COUNT + 40;
	localparam int TIMEOUT_CYCLES = OP_TOTAL * CYCLES_PER_OP + 100;

	logic     clk, rst;
	logic     beg_fsm_cordic, ack_cordic, operation, ready_add_subt;
	fp_word_t data_in, result_add_subt;
	region_t  shift_region_flag;
	logic     ready_cordic, beg_add_subt, ack_add_subt, op_add_subt;
	fp_word_t add_subt_data_a, add_subt_data_b, data_output;
	int       test_id;
	int       results_checked, mismatch_count, protocol_errors;
	integer   seed;        // Random state for angles, flags and ack delays.
	int       cycle_count; // Cycles since time zero.
	int       i;
	int       rnd;

	tb_clock_gen #(.RESET_CYCLES(10)) u_clock_gen (.clk(clk), .rst(rst));

	cordic_coprocessor u_dut (
		.clk               (clk),
		.rst               (rst),
		.beg_fsm_cordic    (beg_fsm_cordic),
		.ack_cordic        (ack_cordic),
		.operation         (operation),
		.ready_add_subt    (ready_add_subt),
		.data_in           (data_in),
		.shift_region_flag (shift_region_flag),
		.result_add_subt   (result_add_subt),
		.ready_cordic      (ready_cordic),
		.beg_add_subt      (beg_add_subt),
		.ack_add_subt      (ack_add_subt),
		.op_add_subt       (op_add_subt),
		.add_subt_data_a   (add_subt_data_a),
		.add_subt_data_b   (add_subt_data_b),
		.data_output       (data_output)
	);

	tb_fp_adder_model #(.SEED(SEED)) u_adder (
		.clk             (clk),
		.rst             (rst),
		.beg_add_subt    (beg_add_subt),
		.ack_add_subt    (ack_add_subt),
		.op_add_subt     (op_add_subt),
		.add_subt_data_a (add_subt_data_a),
		.add_subt_data_b (add_subt_data_b),
		.ready_add_subt  (ready_add_subt),
		.result_add_subt (result_add_subt)
	);

	tb_cordic_checker u_checker (
		.clk               (clk),
		.rst               (rst),
		.beg_fsm_cordic    (beg_fsm_cordic),
		.ack_cordic        (ack_cordic),
		.operation         (operation),
		.data_in           (data_in),
		.shift_region_flag (shift_region_flag),
		.ready_cordic      (ready_cordic),
		.beg_add_subt      (beg_add_subt),
		.ack_add_subt      (ack_add_subt),
		.ready_add_subt    (ready_add_subt),
		.op_add_subt       (op_add_subt),
		.add_subt_data_a   (add_subt_data_a),
		.add_subt_data_b   (add_subt_data_b),
		.data_output       (data_output),
		.test_id           (test_id),
		.results_checked   (results_checked),
		.mismatch_count    (mismatch_count),
		.protocol_errors   (protocol_errors)
	);

	function automatic fp_word_t angle_bits(input real value);
		shortreal narrow;
		narrow = value;
		return $shortrealtobits(narrow);
	endfunction

	//////////////////////////////////////////////////
	// One computation, start to acknowledge.
	//////////////////////////////////////////////////

	task automatic run_computation(input int id, input fp_word_t angle, input logic sine,
		input region_t region, input int ack_delay, input logic stray_start);
		int waited;
		int k;
		@(posedge clk);
		test_id           <= id;
		data_in           <= angle;
		operation         <= sine;
		shift_region_flag <= region;
		beg_fsm_cordic    <= 1'b1;
		@(posedge clk);
		beg_fsm_cordic <= 1'b0;
		waited = 0;
		while (!ready_cordic)
		begin
			@(posedge clk);
			waited++;
			// A second start in mid run, with other data, must change nothing.
			if (stray_start && (waited == 40))
			begin
				beg_fsm_cordic    <= 1'b1;
				data_in           <= ~angle;
				operation         <= ~sine;
				shift_region_flag <= ~region;
			end
			else
				beg_fsm_cordic <= 1'b0;
		end
		for (k = 0; k < ack_delay; k++)
		begin
			beg_fsm_cordic <= stray_start && (k == 0); // Another one while in HOLD.
			@(posedge clk);
		end
		beg_fsm_cordic <= 1'b0;
		ack_cordic     <= 1'b1;
		@(posedge clk);
		ack_cordic <= 1'b0;
	endtask

	initial
	begin
		seed              = SEED;
		beg_fsm_cordic    = 1'b0;
		ack_cordic        = 1'b0;
		operation         = 1'b0;
		data_in           = '0;
		shift_region_flag = '0;
		test_id           = 0;
		@(posedge clk);
		while (rst)
			@(posedge clk);
		repeat (5) @(posedge clk); // Idle outputs are watched here.

		for (i = 0; i < 6; i++) // 0, 0.5 and -0.7 for both operations.
			run_computation(1, angle_bits((i / 2 == 0) ? 0.0 : ((i / 2 == 1) ? 0.5 : -0.7)),
				i[0], 2'b00, 0, 1'b0);
		for (i = 0; i < 8; i++)
			run_computation(2, angle_bits(0.5), i[0], region_t'(i >> 1), 0, 1'b0);
		for (i = 0; i < 4; i++)
			run_computation(3, angle_bits(0.3 - 0.4 * i), i[0], region_t'(i), 2 + ($unsigned(
				$random(seed)) % 14), 1'b1);
		for (i = 0; i < 30; i++)
		begin
			rnd = $random(seed) % 15700; // Within plus or minus pi/2.
			run_computation(4, angle_bits(rnd / 10000.0), 1'($random(seed)),
				region_t'($random(seed)), $unsigned($random(seed)) % 4, 1'b0);
		end

		repeat (3) @(posedge clk);
		if (results_checked != OP_TOTAL)
			$display("Only %0d of %0d computations were compared", results_checked, OP_TOTAL);
		$display("Totals: %0d results compared, %0d mismatches, %0d protocol errors",
			results_checked, mismatch_count, protocol_errors);
		if ((mismatch_count == 0) && (protocol_errors == 0) && (results_checked == OP_TOTAL))
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog.
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
		cycle_count = 0;

endmodule

//--- verification/tb_cordic_checker.sv
`timescale 1ns/1ps

module tb_cordic_checker
	import cordic_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     beg_fsm_cordic,
	input  logic     ack_cordic,
	input  logic     operation,
	input  fp_word_t data_in,
	input  region_t  shift_region_flag,
	input  logic     ready_cordic,
	input  logic     beg_add_subt,
	input  logic     ack_add_subt,
	input  logic     ready_add_subt,
	input  logic     op_add_subt,
	input  fp_word_t add_subt_data_a,
	input  fp_word_t add_subt_data_b,
	input  fp_word_t data_output,
	input  int       test_id,         // Test that the stimulus is running.
	output int       results_checked, // Computations compared so far.
	output int       mismatch_count,  // Wrong values.
	output int       protocol_errors  // Handshake violations.
);

	logic     started;     // The first start has been seen.
	logic     busy;        // A run is in flight in the DUT.
	logic     outstanding; // An adder request has no acknowledge yet.
	logic     checked;     // This run's result has been compared.
	int       strobes;     // Adder requests in this run.
	int       run_id;      // Test of the running computation.
	fp_word_t expected;
	fp_word_t held;        // Output seen when ready first rose.
	fp_word_t op_a_held;   // Operands of the outstanding request.
	fp_word_t op_b_held;
	logic     op_sub_held;

	function automatic string test_name(input int id);
		case (id)
			0:       return "reset_idle";
			1:       return "primary_range";
			2:       return "region_sign";
			3:       return "ack_delay";
			default: return "random_angles";
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Reference model.
	//////////////////////////////////////////////////

	function automatic fp_word_t fp_add(input fp_word_t a, input fp_word_t b);
		shortreal ra;
		shortreal rb;
		ra = $bitstoshortreal(a);
		rb = $bitstoshortreal(b);
		return $shortrealtobits(ra + rb);
	endfunction

	function automatic fp_word_t fp_sub(input fp_word_t a, input fp_word_t b);
		shortreal ra;
		shortreal rb;
		ra = $bitstoshortreal(a);
		rb = $bitstoshortreal(b);
		return $shortrealtobits(ra - rb);
	endfunction

	// Times 2^-amount, done on the exponent; zero keeps its exponent of zero.
	function automatic fp_word_t exp_shift_down(input fp_word_t value, input int amount);
		exp_t e;
		e = value[EXP_MSB:EXP_LSB];
		if (e == '0)
			return value;
		e = exp_t'(e - amount);
		return {value[SIGN_POS], e, value[MAN_W-1:0]};
	endfunction

	function automatic fp_word_t cordic_reference(input fp_word_t angle, input logic sine,
		input region_t region);
		fp_word_t x, y, z;
		fp_word_t x_new, y_new, z_new;
		fp_word_t sx, sy, res;
		logic     flip;
		int       i;
		x = X_INIT;
		y = '0;
		z = angle;
		for (i = 0; i < ITER_COUNT; i++)
		begin
			sx = exp_shift_down(x, i);
			sy = exp_shift_down(y, i);
			if (!z[SIGN_POS]) // Rotate by +atan for a positive angle.
			begin
				x_new = fp_sub(x, sy);
				y_new = fp_add(y, sx);
				z_new = fp_sub(z, ATAN_TABLE[i]);
			end
			else
			begin
				x_new = fp_add(x, sy);
				y_new = fp_sub(y, sx);
				z_new = fp_add(z, ATAN_TABLE[i]);
			end
			x = x_new;
			y = y_new;
			z = z_new;
		end
		res = sine ? y : x;
		if (sine)
			flip = (region == 2'b10) || (region == 2'b11);
		else
			flip = (region == 2'b01) || (region == 2'b10);
		res[SIGN_POS] = res[SIGN_POS] ^ flip;
		return res;
	endfunction

	initial
	begin
		results_checked = 0;
		mismatch_count  = 0;
		protocol_errors = 0;
		started         = 1'b0;
		busy            = 1'b0;
	end

	//////////////////////////////////////////////////
	// Comparison, sampled on the rising edge.
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			busy        = 1'b0;
			outstanding = 1'b0;
			checked     = 1'b0;
		end
		else
		begin
			if (!started && ((ready_cordic !== 1'b0) || (beg_add_subt !== 1'b0) ||
				(ack_add_subt !== 1'b0) || (data_output !== '0)))
			begin
				$display("Mismatch in %s: idle outputs expected 0/0/0/%h, actual %b/%b/%b/%h",
					test_name(0), 32'h0, ready_cordic, beg_add_subt, ack_add_subt, data_output);
				mismatch_count++;
			end
			if (!busy && beg_add_subt)
			begin
				$display("Adder request issued while no computation was running");
				protocol_errors++;
			end
			if (!busy && beg_fsm_cordic)
			begin
				// Start accepted; expected value is fixed from here.
				expected    = cordic_reference(data_in, operation, shift_region_flag);
				run_id      = test_id;
				started     = 1'b1;
				busy        = 1'b1;
				outstanding = 1'b0;
				checked     = 1'b0;
				strobes     = 0;
			end
			else if (busy)
			begin
				// The adder may read its operands at any time until it reports ready.
				if (outstanding && !ready_add_subt && ((add_subt_data_a !== op_a_held) ||
					(add_subt_data_b !== op_b_held) || (op_add_subt !== op_sub_held)))
				begin
					$display("Mismatch in %s: adder operands expected %h %h %b, actual %h %h %b",
						test_name(run_id), op_a_held, op_b_held, op_sub_held,
						add_subt_data_a, add_subt_data_b, op_add_subt);
					mismatch_count++;
				end
				if (beg_add_subt)
				begin
					if (outstanding)
					begin
						$display("Adder request issued while the previous one was outstanding");
						protocol_errors++;
					end
					outstanding = 1'b1;
					op_a_held   = add_subt_data_a;
					op_b_held   = add_subt_data_b;
					op_sub_held = op_add_subt;
					strobes++;
				end
				if (ack_add_subt)
					outstanding = 1'b0;
				if (ready_cordic && !checked)
				begin
					results_checked++;
					if (data_output !== expected)
					begin
						$display("Mismatch in %s: data_output expected %h, actual %h",
							test_name(run_id), expected, data_output);
						mismatch_count++;
					end
					if (strobes != 3 * ITER_COUNT)
					begin
						$display("Mismatch in %s: adder requests expected %0d, actual %0d",
							test_name(run_id), 3 * ITER_COUNT, strobes);
						mismatch_count++;
					end
					held    = data_output;
					checked = 1'b1;
				end
				else if (checked && !ready_cordic)
				begin
					$display("ready_cordic fell before the result was acknowledged");
					protocol_errors++;
					busy = 1'b0;
				end
				else if (checked && (data_output !== held))
				begin
					$display("Mismatch in %s: held data_output expected %h, actual %h",
						test_name(run_id), held, data_output);
					mismatch_count++;
				end
				if (ready_cordic && ack_cordic)
					busy = 1'b0; // DUT is back in IDLE after this edge.
			end
		end
	end

endmodule

//--- verification/tb_fp_adder_model.sv
`timescale 1ns/1ps

module tb_fp_adder_model
	import cordic_pkg::*;
#(
	parameter integer SEED = 0 // Start of the latency stream.
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     beg_add_subt,    // New request.
	input  logic     ack_add_subt,    // Result taken.
	input  logic     op_add_subt,     // 1 subtracts.
	input  fp_word_t add_subt_data_a,
	input  fp_word_t add_subt_data_b,
	output logic     ready_add_subt,
	output fp_word_t result_add_subt
);

	integer   seed;      // Random state for the latency.
	int       remaining; // Edges left until the result appears.
	logic     busy;      // A request is being worked on.
	fp_word_t pending;   // Result waiting for its latency to run out.
	shortreal op_a;
	shortreal op_b;

	initial
	begin
		seed            = SEED;
		busy            = 1'b0;
		remaining       = 0;
		ready_add_subt  = 1'b0;
		result_add_subt = '0;
	end

	always @(posedge clk)
	begin
		if (rst)
		begin
			ready_add_subt <= 1'b0;
			busy = 1'b0;
		end
		else
		begin
			if (beg_add_subt)
			begin
				op_a = $bitstoshortreal(add_subt_data_a); // Operands are taken at the strobe.
				op_b = $bitstoshortreal(add_subt_data_b);
				if (op_add_subt)
					pending = $shortrealtobits(op_a - op_b);
				else
					pending = $shortrealtobits(op_a + op_b);
				remaining = 1 + ($unsigned($random(seed)) % 4); // 1 to 4 cycles.
				busy = 1'b1;
			end
			else if (busy)
			begin
				remaining = remaining - 1;
				if (remaining == 0)
				begin
					ready_add_subt  <= 1'b1;
					result_add_subt <= pending;
					busy = 1'b0;
				end
			end
			if (ack_add_subt)
				ready_add_subt <= 1'b0; // Result is held up to here.
		end
	end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
	parameter int RESET_CYCLES = 10 // Reset length in clock cycles.
)
(
	output logic clk,
	output logic rst
);

	// 4 ns period, so each half lasts 2 ns.
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0; // Released on an edge like every other input.
	end

endmodule

//--- verilog/cordic_coprocessor.sv
`timescale 1ns/1ps

module cordic_coprocessor
	import cordic_pkg::*;
(
	input  logic     clk,               // System clock.
	input  logic     rst,               // Synchronous reset, active high.
	input  logic     beg_fsm_cordic,    // Start strobe from the processor.
	input  logic     ack_cordic,        // Processor has taken the result.
	input  logic     operation,         // 1 asks for sine, 0 for cosine.
	input  logic     ready_add_subt,    // Adder has a result.
	input  fp_word_t data_in,           // Angle in radians, already in the primary range.
	input  region_t  shift_region_flag, // Quadrant the original angle came from.
	input  fp_word_t result_add_subt,   // Sum or difference from the adder.
	output logic     ready_cordic,      // Result is valid on data_output.
	output logic     beg_add_subt,      // Start strobe toward the adder.
	output logic     ack_add_subt,      // Adder result has been taken.
	output logic     op_add_subt,       // 1 subtracts, 0 adds.
	output fp_word_t add_subt_data_a,   // First adder operand.
	output fp_word_t add_subt_data_b,   // Second adder operand.
	output fp_word_t data_output        // Final sine or cosine.
);

	// Control from the sequencer.
	logic     load_init;
	logic     latch_current;
	logic     capture_next;
	logic     finish;
	var_sel_t var_sel;
	iter_t    iter_index;

	// Variable bank contents.
	fp_word_t cur_x, cur_y, cur_z;
	fp_word_t next_x, next_y;

	// The sequencer paces everything, one adder transaction at a time.
	cordic_sequencer u_sequencer (
		.clk            (clk),
		.rst            (rst),
		.beg_fsm_cordic (beg_fsm_cordic),
		.ack_cordic     (ack_cordic),
		.ready_add_subt (ready_add_subt),
		.ready_cordic   (ready_cordic),
		.beg_add_subt   (beg_add_subt),
		.ack_add_subt   (ack_add_subt),
		.load_init      (load_init),
		.latch_current  (latch_current),
		.capture_next   (capture_next),
		.var_sel        (var_sel),
		.iter_index     (iter_index),
		.finish         (finish)
	);

	cordic_var_bank u_var_bank (
		.clk             (clk),
		.rst             (rst),
		.load_init       (load_init),
		.latch_current   (latch_current),
		.capture_next    (capture_next),
		.var_sel         (var_sel),
		.data_in         (data_in),
		.result_add_subt (result_add_subt),
		.cur_x           (cur_x),
		.cur_y           (cur_y),
		.cur_z           (cur_z),
		.next_x          (next_x),
		.next_y          (next_y)
	);

	cordic_step_operands u_step_operands (
		.clk             (clk),
		.rst             (rst),
		.latch_current   (latch_current),
		.var_sel         (var_sel),
		.iter_index      (iter_index),
		.cur_x           (cur_x),
		.cur_y           (cur_y),
		.cur_z           (cur_z),
		.add_subt_data_a (add_subt_data_a),
		.add_subt_data_b (add_subt_data_b),
		.op_add_subt     (op_add_subt)
	);

	// Output side, with the quadrant correction.
	cordic_result_stage u_result_stage (
		.clk               (clk),
		.rst               (rst),
		.load_init         (load_init),
		.finish            (finish),
		.operation         (operation),
		.shift_region_flag (shift_region_flag),
		.next_x            (next_x),
		.next_y            (next_y),
		.data_output       (data_output)
	);

endmodule

//--- verilog/cordic_result_stage.sv
`timescale 1ns/1ps

module cordic_result_stage
	import cordic_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     load_init,         // Start of a run.
	input  logic     finish,            // Last iteration is complete.
	input  logic     operation,         // 1 selects sine.
	input  region_t  shift_region_flag, // Quadrant of the original angle.
	input  fp_word_t next_x,            // Cosine before the correction.
	input  fp_word_t next_y,            // Sine before the correction.
	output fp_word_t data_output
);

	logic     operation_q; // Kept for the whole run.
	region_t  region_q;
	fp_word_t picked;      // Raw result.
	logic     negate;      // Flip the sign for this quadrant.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			operation_q <= 1'b0;
			region_q    <= '0;
		end
		else if (load_init)
		begin
			operation_q <= operation;
			region_q    <= shift_region_flag;
		end
	end

	//////////////////////////////////////////////////
	// Quadrant correction.
	//////////////////////////////////////////////////

	assign picked = operation_q ? next_y : next_x;
	// Sine is negative in regions 10 and 11, cosine in 01 and 10.
	assign negate = operation_q ? region_q[1] : (region_q[1] ^ region_q[0]);

	always_ff @(posedge clk)
	begin
		if (rst)
			data_output <= '0;
		else if (finish)
			data_output <= {picked[SIGN_POS] ^ negate, picked[SIGN_POS-1:0]}; // Held through HOLD.
	end

endmodule

//--- cordic_core/cordic_step_operands.sv
`timescale 1ns/1ps

module cordic_step_operands
	import cordic_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     latch_current,   // Current registers load on this edge.
	input  var_sel_t var_sel,         // Variable being updated.
	input  iter_t    iter_index,      // Shift amount and table address.
	input  fp_word_t cur_x,
	input  fp_word_t cur_y,
	input  fp_word_t cur_z,
	output fp_word_t add_subt_data_a, // The variable itself.
	output fp_word_t add_subt_data_b, // The term added to it.
	output logic     op_add_subt      // 1 subtracts.
);

	logic     latch_q;   // Current values settled one edge ago.
	fp_word_t shift_x_q; // X times 2^-i.
	fp_word_t shift_y_q; // Y times 2^-i.
	fp_word_t atan_q;    // atan(2^-i).
	logic     sign_z_q;  // 1 when Z is negative.

	// Multiply by 2^-shift by lowering the exponent.
	// A zero exponent is kept, so zero stays zero and does not wrap.
	function automatic fp_word_t scale_pow2(input fp_word_t value, input iter_t shift);
		exp_t exp_in;
		exp_in = value[EXP_MSB:EXP_LSB];
		if (exp_in == '0)
			return value;
		return {value[SIGN_POS], exp_t'(exp_in - exp_t'(shift)), value[MAN_W-1:0]};
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
			latch_q <= 1'b0;
		else
			latch_q <= latch_current;
	end

	//////////////////////////////////////////////////
	// Per-iteration terms, registered once.
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (latch_q)
		begin
			shift_x_q <= scale_pow2(cur_x, iter_index);
			shift_y_q <= scale_pow2(cur_y, iter_index);
			atan_q    <= ATAN_TABLE[iter_index];
			sign_z_q  <= cur_z[SIGN_POS]; // Direction of the rotation.
		end
	end

	// Operand routing.
	// With s the sign of Z, X subtracts sY, Y adds sX and Z subtracts s*atan.
	always_comb
	begin
		case (var_sel)
			VAR_X:
			begin
				add_subt_data_a = cur_x;
				add_subt_data_b = shift_y_q;
				op_add_subt     = ~sign_z_q;
			end
			VAR_Y:
			begin
				add_subt_data_a = cur_y;
				add_subt_data_b = shift_x_q;
				op_add_subt     = sign_z_q; // Adds for a positive Z.
			end
			default:
			begin
				add_subt_data_a = cur_z;
				add_subt_data_b = atan_q;
				op_add_subt     = ~sign_z_q;
			end
		endcase
	end

	// The table has no entry past the last iteration.
	a_iter_range: assert property (@(posedge clk) disable iff (rst)
		latch_q |-> (iter_index < ITER_COUNT));

endmodule

//--- cordic_core/cordic_var_bank.sv
`timescale 1ns/1ps

module cordic_var_bank
	import cordic_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     load_init,       // Start of a run.
	input  logic     latch_current,   // Start of an iteration.
	input  logic     capture_next,    // Adder result is valid.
	input  var_sel_t var_sel,         // Which next register takes the result.
	input  fp_word_t data_in,         // Angle from the processor.
	input  fp_word_t result_add_subt, // Adder result.
	output fp_word_t cur_x,
	output fp_word_t cur_y,
	output fp_word_t cur_z,
	output fp_word_t next_x,
	output fp_word_t next_y
);

	fp_word_t next_z; // Only the sequencer steps need the updated angle.

	//////////////////////////////////////////////////
	// Next registers.
	//////////////////////////////////////////////////

	// The start values go into the next registers and reach the current
	// ones through the same latch that every later iteration uses.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			next_x <= '0;
			next_y <= '0;
			next_z <= '0;
		end
		else if (load_init)
		begin
			next_x <= X_INIT;
			next_y <= Y_INIT;
			next_z <= data_in; // Z starts at the angle itself.
		end
		else if (capture_next)
		begin
			case (var_sel)
				VAR_X:   next_x <= result_add_subt;
				VAR_Y:   next_y <= result_add_subt;
				default: next_z <= result_add_subt;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Current registers.
	//////////////////////////////////////////////////

	// These stay fixed for all three transactions of an iteration.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cur_x <= '0;
			cur_y <= '0;
			cur_z <= '0;
		end
		else if (latch_current)
		begin
			cur_x <= next_x;
			cur_y <= next_y;
			cur_z <= next_z;
		end
	end

endmodule

//--- cordic_core/cordic_sequencer.sv
`timescale 1ns/1ps

module cordic_sequencer
	import cordic_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     beg_fsm_cordic, // Start, taken only in IDLE.
	input  logic     ack_cordic,     // Releases HOLD.
	input  logic     ready_add_subt, // Adder result is waiting.
	output logic     ready_cordic,   // High for the whole of HOLD.
	output logic     beg_add_subt,   // One cycle per transaction.
	output logic     ack_add_subt,   // One cycle after ready is seen.
	output logic     load_init,      // Samples the start values.
	output logic     latch_current,  // Copies next into current.
	output logic     capture_next,   // Stores the adder result.
	output var_sel_t var_sel,        // Variable of the running transaction.
	output iter_t    iter_index,     // Iteration number.
	output logic     finish          // Output register enable.
);

	seq_state_t state, state_nxt;
	iter_t      iter_cnt;    // Counts iterations up from zero.
	var_sel_t   var_cnt;     // Walks X, Y, Z.
	logic       last_iter;   // Iteration ITER_COUNT-1 is running.
	logic       req_pending; // A strobe went out and has not been acknowledged.

	assign last_iter = (iter_cnt == iter_t'(ITER_COUNT - 1));

	//////////////////////////////////////////////////
	// Next state.
	//////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:        if (beg_fsm_cordic) state_nxt = LOAD;
			LOAD:        state_nxt = LATCH;
			LATCH:       state_nxt = REQUEST;
			REQUEST:     state_nxt = WAIT_RESULT;
			WAIT_RESULT:
			begin
				// Leave once the acknowledge cycle has gone by.
				if (ack_add_subt)
					state_nxt = (var_cnt == VAR_Z) ? ADVANCE : REQUEST;
			end
			ADVANCE:     state_nxt = last_iter ? FINISH : LATCH;
			FINISH:      state_nxt = HOLD;
			HOLD:        if (ack_cordic) state_nxt = IDLE;
			default:     state_nxt = IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// State, counters and the adder acknowledge.
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state        <= IDLE;
			iter_cnt     <= '0;
			var_cnt      <= VAR_X;
			ack_add_subt <= 1'b0;
			req_pending  <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// Only one strobe per ready; the adder keeps ready up until it sees ack.
			ack_add_subt <= (state == WAIT_RESULT) && ready_add_subt && !ack_add_subt;

			if (state == LOAD)
			begin
				iter_cnt <= '0;    // Fresh run.
				var_cnt  <= VAR_X;
			end

			// The variable moves on after its result is stored.
			if ((state == WAIT_RESULT) && ack_add_subt)
				var_cnt <= (var_cnt == VAR_Z) ? VAR_X : var_sel_t'(var_cnt + 2'd1);

			if ((state == ADVANCE) && !last_iter)
				iter_cnt <= iter_t'(iter_cnt + 1'b1); // Index stops at the last one.

			if (beg_add_subt)
				req_pending <= 1'b1;
			else if (ack_add_subt)
				req_pending <= 1'b0;
		end
	end

	// Decoded controls.
	assign load_init     = (state == IDLE) && beg_fsm_cordic;
	assign latch_current = (state == LOAD) || ((state == ADVANCE) && !last_iter);
	assign beg_add_subt  = (state == REQUEST);
	assign capture_next  = ack_add_subt;                 // Result is still held by the adder.
	assign finish        = (state == FINISH);
	assign ready_cordic  = (state == HOLD);
	assign var_sel       = var_cnt;
	assign iter_index    = iter_cnt;

	// The adder takes one transaction at a time.
	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		beg_add_subt |-> !req_pending);

endmodule

//--- common/cordic_pkg.sv
package cordic_pkg;

	//////////////////////////////////////////////////
	// Word format of IEEE single precision.
	//////////////////////////////////////////////////

	localparam int WORD_W = 32;           // Width of a floating-point word.
	localparam int EXP_W  = 8;            // Width of the exponent field.
	localparam int MAN_W  = 23;           // Width of the mantissa field.

	localparam int SIGN_POS = WORD_W - 1; // Sign bit position.
	localparam int EXP_MSB  = WORD_W - 2; // Top bit of the exponent.
	localparam int EXP_LSB  = MAN_W;      // Exponent sits right above the mantissa.

	//////////////////////////////////////////////////
	// Iteration control.
	//////////////////////////////////////////////////

	localparam int ITER_COUNT = 24;       // One iteration per mantissa bit plus the hidden one.
	localparam int ITER_W     = 5;        // Enough to index 0 to 23.

	// Plain vector types for the widths that carry a meaning.
	typedef logic [WORD_W-1:0] fp_word_t;
	typedef logic [EXP_W-1:0]  exp_t;
	typedef logic [ITER_W-1:0] iter_t;
	typedef logic [1:0]        var_sel_t;
	typedef logic [1:0]        region_t;

	// Variable codes, in the order the adder requests go out.
	localparam var_sel_t VAR_X = 2'd0;
	localparam var_sel_t VAR_Y = 2'd1;
	localparam var_sel_t VAR_Z = 2'd2;

	//////////////////////////////////////////////////
	// Starting point of the rotation.
	//////////////////////////////////////////////////

	// X starts at 1/K = 0.607252935 so the CORDIC gain cancels out.
	localparam fp_word_t X_INIT = 32'h3f1b74ee;
	localparam fp_word_t Y_INIT = 32'h00000000; // Y starts at zero.

	// Entry i holds atan(2^-i) in single precision.
	localparam fp_word_t ATAN_TABLE [ITER_COUNT] = '{
		32'h3f490fdb, // pi/4.
		32'h3eed6338,
		32'h3e7adbb0,
		32'h3dfeadd5,
		32'h3d7faade,
		32'h3cffeaae,
		32'h3c7ffaab,
		32'h3bfffeab,
		32'h3b7fffab,
		32'h3affffeb,
		32'h3a7ffffb,
		32'h39ffffff,
		32'h39800000, // From here on atan(x) rounds to x itself.
		32'h39000000,
		32'h38800000,
		32'h38000000,
		32'h37800000,
		32'h37000000,
		32'h36800000,
		32'h36000000,
		32'h35800000,
		32'h35000000,
		32'h34800000,
		32'h34000000
	};

	// Sequencer states.
	typedef enum logic [2:0] {
		IDLE,        // Waiting for a start from the processor.
		LOAD,        // Initial values move into the current registers.
		LATCH,       // Shifted operands and the table entry are registered.
		REQUEST,     // Strobe toward the adder.
		WAIT_RESULT, // Adder is busy, then the result is acknowledged.
		ADVANCE,     // Next iteration, or the end of the run.
		FINISH,      // Output register loads.
		HOLD         // Result is offered until the processor acknowledges.
	} seq_state_t;

endpackage
